/* source/x11_pkg.sv */
package x11_pkg;

  // ------------------------------
  // widths
  localparam int data_w      = 32;   // bus data and register words
  localparam int addr_dec_w  = 20;   // low address bits decoded
  localparam int hash_w      = 256;
  localparam int hash_words  = 8;    // hash split into 32 bit words

  // input fifo geometry
  localparam int fifo_depth  = 512;
  localparam int fifo_addr_w = 9;
  localparam int fifo_cnt_w  = 10;   // holds 0 .. fifo_depth

  // version word, 0xYYMMDDss
  localparam logic [data_w-1:0] build_date = 32'h16081501;

  // ------------------------------
  // decoded register map
  typedef enum logic [addr_dec_w-1:0] {
    reg_ctrl       = 20'h00000,  // global control
    reg_status     = 20'h00004,  // global status, read only
    reg_version    = 20'h0000C,  // build date, read only
    reg_sha_ctrl   = 20'h00100,
    reg_sha_status = 20'h00104,
    reg_push       = 20'h0010C,  // write pushes, read gives count
    reg_hash_base  = 20'h00110,  // eight hash words follow
    reg_wr_count   = 20'h00130,
    reg_rd_count   = 20'h00134
  } reg_addr_e;

  // control bits
  localparam int ctrl_enable_bit = 0;
  localparam int sha_enable_bit  = 0;
  localparam int sha_reset_bit   = 1;   // one-shot, self clearing
  localparam int sha_dbl_bit     = 4;   // sha256(sha256(x))

  // sha status word
  localparam int sst_ready_bit   = 0;
  localparam int sst_valid_bit   = 1;
  localparam int sst_empty_bit   = 4;
  localparam int sst_afull_bit   = 5;
  localparam int sst_full_bit    = 6;

  // global status word
  localparam int gst_enabled_bit = 0;
  localparam int gst_sha_act_bit = 4;

endpackage

/* source/bus_regs.sv */
`timescale 1ns/1ps

module bus_regs (
  input  logic                            bus_clk,
  input  logic                            bus_rstn,
  // system bus slave
  input  logic [31:0]                     sys_addr_i,
  input  logic [31:0]                     sys_wdata_i,
  input  logic                            sys_wen_i,
  input  logic                            sys_ren_i,
  output logic [31:0]                     sys_rdata_o,
  output logic                            sys_ack_o,
  output logic                            sys_err_o,
  // readable state from the other blocks
  input  logic [31:0]                     status_i,
  input  logic [31:0]                     sha_status_i,
  input  logic [x11_pkg::fifo_cnt_w-1:0]  fifo_count_i,
  input  logic [x11_pkg::hash_w-1:0]      hash_i,
  // control out
  output logic [31:0]                     ctrl_word_o,
  output logic [31:0]                     sha_ctrl_word_o,
  output logic                            push_en_o,
  output logic [31:0]                     push_data_o
);

  localparam int hash_sel_w = $clog2(x11_pkg::hash_words);

  logic [x11_pkg::addr_dec_w-1:0] addr;       // decoded part of the address
  logic [x11_pkg::addr_dec_w-1:0] hash_off;   // offset into the hash window
  logic [hash_sel_w-1:0]          hash_sel;
  logic                           hash_hit;
  logic [x11_pkg::data_w-1:0]     ctrl_q;
  logic [x11_pkg::data_w-1:0]     sha_ctrl_q;
  logic                           push_en_q;
  logic [x11_pkg::data_w-1:0]     push_data_q;
  logic [x11_pkg::data_w-1:0]     rdata_next;
  logic                           ack_q;

  assign addr     = sys_addr_i[x11_pkg::addr_dec_w-1:0];
  assign hash_off = addr - x11_pkg::reg_hash_base;    // wraps high below the base
  assign hash_sel = hash_off[2 +: hash_sel_w];
  assign hash_hit = (hash_off < x11_pkg::addr_dec_w'(4 * x11_pkg::hash_words))
                    && (hash_off[1:0] == 2'b00);

  // ------------------------------
  // write side

  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      ctrl_q     <= '0;
      sha_ctrl_q <= '0;
      push_en_q  <= 1'b0;
    end else begin
      push_en_q                           <= 1'b0;  // single cycle strobe
      sha_ctrl_q[x11_pkg::sha_reset_bit]  <= 1'b0;  // reset bit lives one cycle
      if (sys_wen_i) begin
        case (addr)
          x11_pkg::reg_ctrl:     ctrl_q     <= sys_wdata_i;
          x11_pkg::reg_sha_ctrl: sha_ctrl_q <= sys_wdata_i;
          x11_pkg::reg_push:     push_en_q  <= 1'b1;
          default: ;                                // read only or unmapped
        endcase
      end
    end
  end

  // push word, qualified by push_en_q
  always_ff @(posedge bus_clk) begin
    if (sys_wen_i && (addr == x11_pkg::reg_push)) begin
      push_data_q <= sys_wdata_i;
    end
  end

  assign ctrl_word_o     = ctrl_q;
  assign sha_ctrl_word_o = sha_ctrl_q;
  assign push_en_o       = push_en_q;
  assign push_data_o     = push_data_q;

  // ------------------------------
  // read side

  always_comb begin
    rdata_next = '0;                          // unmapped reads give zero
    case (addr)
      x11_pkg::reg_ctrl:       rdata_next = ctrl_q;
      x11_pkg::reg_status:     rdata_next = status_i;
      x11_pkg::reg_version:    rdata_next = x11_pkg::build_date;
      x11_pkg::reg_sha_ctrl:   rdata_next = sha_ctrl_q;
      x11_pkg::reg_sha_status: rdata_next = sha_status_i;
      x11_pkg::reg_push,
      x11_pkg::reg_wr_count,
      x11_pkg::reg_rd_count:   rdata_next = x11_pkg::data_w'(fifo_count_i);  // one count
      default: begin
        if (hash_hit) begin
          // word k holds hash bits 32k+31 .. 32k
          rdata_next = hash_i[hash_sel*x11_pkg::data_w +: x11_pkg::data_w];
        end
      end
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (sys_ren_i) begin
      sys_rdata_o <= rdata_next;              // lines up with the ack
    end
  end

  // every strobe gets an ack one cycle later
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sys_wen_i | sys_ren_i;
    end
  end

  assign sys_ack_o = ack_q;
  assign sys_err_o = 1'b0;                    // no error responses on this bus

endmodule

/* source/sha256_fifo.sv */
`timescale 1ns/1ps

module sha256_fifo (
  input  logic                            bus_clk,
  input  logic                            bus_rstn,
  input  logic                            flush_n_i,     // sync flush, low active
  input  logic                            wr_en_i,
  input  logic [31:0]                     wr_data_i,
  input  logic                            rd_en_i,
  output logic [31:0]                     rd_data_o,
  output logic                            rd_valid_o,
  output logic                            empty_o,
  output logic                            almost_full_o,
  output logic                            full_o,
  output logic [x11_pkg::fifo_cnt_w-1:0]  count_o
);

  logic [x11_pkg::data_w-1:0]      mem [x11_pkg::fifo_depth];
  logic [x11_pkg::fifo_addr_w-1:0] wr_ptr;
  logic [x11_pkg::fifo_addr_w-1:0] rd_ptr;
  logic [x11_pkg::fifo_cnt_w-1:0]  count;
  logic                            wr_ok;
  logic                            rd_ok;
  logic                            rd_valid_q;

  assign wr_ok = wr_en_i && !full_o;    // writes while full are lost
  assign rd_ok = rd_en_i && !empty_o;

  // pointers and fill level
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn || !flush_n_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_ok;
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;            // none, or both at once
      endcase
    end
  end

  // storage and read port
  always_ff @(posedge bus_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data_i;
    end
    if (rd_ok) begin
      rd_data_o <= mem[rd_ptr];
    end
  end

  assign rd_valid_o    = rd_valid_q;
  assign count_o       = count;
  assign empty_o       = (count == '0);
  assign full_o        = (count == x11_pkg::fifo_cnt_w'(x11_pkg::fifo_depth));
  assign almost_full_o = (count >= x11_pkg::fifo_cnt_w'(x11_pkg::fifo_depth - 1));

endmodule

/* source/sha256_ctrl.sv */
`timescale 1ns/1ps

module sha256_ctrl (
  input  logic                        bus_clk,
  input  logic                        bus_rstn,
  input  logic [31:0]                 ctrl_word_i,
  input  logic [31:0]                 sha_ctrl_word_i,
  input  logic                        fifo_empty_i,
  input  logic                        fifo_almost_full_i,
  input  logic                        fifo_full_i,
  input  logic                        engine_ready_i,
  input  logic                        hash_valid_i,
  input  logic [x11_pkg::hash_w-1:0]  hash_data_i,
  output logic                        sha_rstn_o,       // fifo flush, low while idle
  output logic                        engine_start_o,
  output logic                        dbl_hash_o,
  output logic [x11_pkg::hash_w-1:0]  hash_o,
  output logic [31:0]                 status_o,
  output logic [31:0]                 sha_status_o
);

  logic                       enabled;
  logic                       act_next;
  logic                       act_q;        // sha section activated
  logic                       start_q;
  logic                       valid_d;
  logic [x11_pkg::hash_w-1:0] hash_q;

  assign enabled  = ctrl_word_i[x11_pkg::ctrl_enable_bit];
  assign act_next = enabled
                    && sha_ctrl_word_i[x11_pkg::sha_enable_bit]
                    && !sha_ctrl_word_i[x11_pkg::sha_reset_bit];

  // ------------------------------
  // activation and start
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      act_q   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      act_q   <= act_next;
      // never two starts back to back
      start_q <= act_q && !fifo_empty_i && engine_ready_i && !start_q;
    end
  end

  // hash capture on the valid rising edge, zero while idle
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn || !act_q) begin
      valid_d <= 1'b0;
      hash_q  <= '0;
    end else begin
      valid_d <= hash_valid_i;
      if (hash_valid_i && !valid_d) hash_q <= hash_data_i;
    end
  end

  assign sha_rstn_o     = act_q;
  assign engine_start_o = start_q;
  assign dbl_hash_o     = act_q && sha_ctrl_word_i[x11_pkg::sha_dbl_bit];
  assign hash_o         = hash_q;

  // ------------------------------
  // status words
  always_comb begin
    status_o                            = '0;
    status_o[x11_pkg::gst_enabled_bit]  = enabled;
    status_o[x11_pkg::gst_sha_act_bit]  = act_q;
    sha_status_o                        = '0;
    sha_status_o[x11_pkg::sst_ready_bit] = engine_ready_i;
    sha_status_o[x11_pkg::sst_valid_bit] = hash_valid_i;
    sha_status_o[x11_pkg::sst_empty_bit] = fifo_empty_i;
    sha_status_o[x11_pkg::sst_afull_bit] = fifo_almost_full_i;
    sha_status_o[x11_pkg::sst_full_bit]  = fifo_full_i;
  end

endmodule

/* source/x11_regs_top.sv */
`timescale 1ns/1ps

module x11_regs_top (
  input  logic                        bus_clk,
  input  logic                        bus_rstn,
  // system bus
  input  logic [31:0]                 sys_addr_i,
  input  logic [31:0]                 sys_wdata_i,
  input  logic                        sys_wen_i,
  input  logic                        sys_ren_i,
  output logic [31:0]                 sys_rdata_o,
  output logic                        sys_ack_o,
  output logic                        sys_err_o,
  // sha256 engine side
  input  logic                        fifo_rd_en_i,
  output logic [31:0]                 fifo_rd_data_o,
  output logic                        fifo_rd_valid_o,
  output logic                        fifo_empty_o,      // engine sees remaining data
  output logic                        engine_start_o,
  output logic                        engine_dbl_hash_o,
  input  logic                        engine_ready_i,
  input  logic                        hash_valid_i,
  input  logic [x11_pkg::hash_w-1:0]  hash_data_i
);

  logic [31:0]                    ctrl_word;
  logic [31:0]                    sha_ctrl_word;
  logic [31:0]                    status;
  logic [31:0]                    sha_status;
  logic                           push_en;
  logic [31:0]                    push_data;
  logic                           sha_rstn;
  logic                           fifo_almost_full;
  logic                           fifo_full;
  logic [x11_pkg::fifo_cnt_w-1:0] fifo_count;
  logic [x11_pkg::hash_w-1:0]     hash;

  bus_regs u_bus_regs (
    .bus_clk         (bus_clk),
    .bus_rstn        (bus_rstn),
    .sys_addr_i      (sys_addr_i),
    .sys_wdata_i     (sys_wdata_i),
    .sys_wen_i       (sys_wen_i),
    .sys_ren_i       (sys_ren_i),
    .sys_rdata_o     (sys_rdata_o),
    .sys_ack_o       (sys_ack_o),
    .sys_err_o       (sys_err_o),
    .status_i        (status),
    .sha_status_i    (sha_status),
    .fifo_count_i    (fifo_count),
    .hash_i          (hash),
    .ctrl_word_o     (ctrl_word),
    .sha_ctrl_word_o (sha_ctrl_word),
    .push_en_o       (push_en),
    .push_data_o     (push_data)
  );

  sha256_fifo u_sha256_fifo (
    .bus_clk       (bus_clk),
    .bus_rstn      (bus_rstn),
    .flush_n_i     (sha_rstn),        // emptied while not activated
    .wr_en_i       (push_en),
    .wr_data_i     (push_data),
    .rd_en_i       (fifo_rd_en_i),
    .rd_data_o     (fifo_rd_data_o),
    .rd_valid_o    (fifo_rd_valid_o),
    .empty_o       (fifo_empty_o),
    .almost_full_o (fifo_almost_full),
    .full_o        (fifo_full),
    .count_o       (fifo_count)
  );

  sha256_ctrl u_sha256_ctrl (
    .bus_clk            (bus_clk),
    .bus_rstn           (bus_rstn),
    .ctrl_word_i        (ctrl_word),
    .sha_ctrl_word_i    (sha_ctrl_word),
    .fifo_empty_i       (fifo_empty_o),
    .fifo_almost_full_i (fifo_almost_full),
    .fifo_full_i        (fifo_full),
    .engine_ready_i     (engine_ready_i),
    .hash_valid_i       (hash_valid_i),
    .hash_data_i        (hash_data_i),
    .sha_rstn_o         (sha_rstn),
    .engine_start_o     (engine_start_o),
    .dbl_hash_o         (engine_dbl_hash_o),
    .hash_o             (hash),
    .status_o           (status),
    .sha_status_o       (sha_status)
  );

endmodule

/* tb/x11_regs_properties.sv */
`timescale 1ns/1ps

module x11_regs_properties (
  input logic bus_clk,
  input logic bus_rstn,
  input logic sys_wen_i,
  input logic sys_ren_i,
  input logic sys_ack_i,
  input logic fifo_full_i,
  input logic fifo_empty_i,
  input logic engine_start_i,
  input logic fifo_rd_en_i,
  input logic fifo_rd_valid_i
);

  // ------------------------------
  // bus: ack exactly one cycle after a strobe
  ack_after_strobe: assert property (@(posedge bus_clk) disable iff (!bus_rstn)
    (sys_wen_i || sys_ren_i) |=> sys_ack_i)
    else $error("bus ack missing one cycle after a strobe");

  no_ack_without_strobe: assert property (@(posedge bus_clk) disable iff (!bus_rstn)
    !(sys_wen_i || sys_ren_i) |=> !sys_ack_i)
    else $error("bus ack without a strobe in the cycle before");

  // ------------------------------
  // fifo and engine side
  full_not_empty: assert property (@(posedge bus_clk) disable iff (!bus_rstn)
    !(fifo_full_i && fifo_empty_i))
    else $error("fifo reports full and empty at once");

  start_single: assert property (@(posedge bus_clk) disable iff (!bus_rstn)
    engine_start_i |=> !engine_start_i)
    else $error("start pulse high for two cycles");

  valid_after_read: assert property (@(posedge bus_clk) disable iff (!bus_rstn)
    $rose(fifo_rd_valid_i) |-> $past(fifo_rd_en_i))
    else $error("read valid rose without a read enable");

endmodule

bind x11_regs_top x11_regs_properties u_x11_regs_properties (
  .bus_clk         (bus_clk),
  .bus_rstn        (bus_rstn),
  .sys_wen_i       (sys_wen_i),
  .sys_ren_i       (sys_ren_i),
  .sys_ack_i       (sys_ack_o),
  .fifo_full_i     (fifo_full),
  .fifo_empty_i    (fifo_empty_o),
  .engine_start_i  (engine_start_o),
  .fifo_rd_en_i    (fifo_rd_en_i),
  .fifo_rd_valid_i (fifo_rd_valid_o)
);

/* tb/tb_x11_regs.sv */
`timescale 1ns/1ps

module tb_x11_regs;

  // ------------------------------
  // register map and constants
  localparam logic [31:0] a_ctrl       = 32'h000;
  localparam logic [31:0] a_status     = 32'h004;
  localparam logic [31:0] a_version    = 32'h00C;
  localparam logic [31:0] a_sha_ctrl   = 32'h100;
  localparam logic [31:0] a_sha_status = 32'h104;
  localparam logic [31:0] a_push       = 32'h10C;  // reads give the count
  localparam logic [31:0] a_hash_base  = 32'h110;
  localparam logic [31:0] a_wr_count   = 32'h130;
  localparam logic [31:0] a_rd_count   = 32'h134;
  localparam logic [31:0] version_word = 32'h16081501;
  localparam int          fifo_words   = 512;
  localparam int          ack_limit    = 8;     // cycles allowed per access
  localparam int          drain_limit  = 4000;
  localparam int          hash_limit   = 400;

  logic          bus_clk;
  logic          bus_rstn;
  logic [31:0]   sys_addr_i;
  logic [31:0]   sys_wdata_i;
  logic          sys_wen_i;
  logic          sys_ren_i;
  logic [31:0]   sys_rdata_o;
  logic          sys_ack_o;
  logic          sys_err_o;
  logic          fifo_rd_en_i;
  logic [31:0]   fifo_rd_data_o;
  logic          fifo_rd_valid_o;
  logic          fifo_empty_o;
  logic          engine_start_o;
  logic          engine_dbl_hash_o;
  logic          engine_ready_i;
  logic          hash_valid_i;
  logic [255:0]  hash_data_i;

  // reference model
  logic [31:0]   m_ctrl;
  logic [31:0]   m_sha_ctrl;
  logic [255:0]  m_hash;        // last hash the engine presented
  logic [31:0]   m_fifo[$];
  int            errors;
  int            checks;
  int            timeouts;

  // engine model state
  logic          pop_on;        // engine drains the FIFO
  logic          hash_on;       // engine answers starts
  logic          busy;
  int            hold;
  int            hashes_seen;
  logic          rd_en_q;       // read enable driven last cycle
  logic          empty_q;       // FIFO empty in the last cycle
  logic          rd_next;
  logic          valid_next;
  logic [255:0]  next_hash;
  logic [31:0]   pop_exp;
  int            eng_k;

  // main sequence scratch
  logic [31:0]   seed_val;
  logic [31:0]   word;
  logic [31:0]   c_word;
  logic [31:0]   s_word;
  logic [31:0]   exp_st;
  int            i;
  int            k;
  int            n;
  int            seen0;

  x11_regs_top u_x11_regs_top (
    .bus_clk           (bus_clk),
    .bus_rstn          (bus_rstn),
    .sys_addr_i        (sys_addr_i),
    .sys_wdata_i       (sys_wdata_i),
    .sys_wen_i         (sys_wen_i),
    .sys_ren_i         (sys_ren_i),
    .sys_rdata_o       (sys_rdata_o),
    .sys_ack_o         (sys_ack_o),
    .sys_err_o         (sys_err_o),
    .fifo_rd_en_i      (fifo_rd_en_i),
    .fifo_rd_data_o    (fifo_rd_data_o),
    .fifo_rd_valid_o   (fifo_rd_valid_o),
    .fifo_empty_o      (fifo_empty_o),
    .engine_start_o    (engine_start_o),
    .engine_dbl_hash_o (engine_dbl_hash_o),
    .engine_ready_i    (engine_ready_i),
    .hash_valid_i      (hash_valid_i),
    .hash_data_i       (hash_data_i)
  );

  always #20 bus_clk = ~bus_clk;  // 40 ns period

  // ------------------------------
  // bus helpers, entered 2 ns after a rising edge

  task automatic wait_cycles(input int cnt);
    repeat (cnt) begin
      @(posedge bus_clk);
      #2;
    end
  endtask

  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    @(posedge bus_clk);
    #2;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    cycles    = 1;
    while (!sys_ack_o && cycles < ack_limit) begin  // ack expected right away
      @(posedge bus_clk);
      #2;
      cycles++;
    end
    rdata = sys_rdata_o;
    if (!sys_ack_o) begin
      timeouts++;
      $display("no acknowledge for the access to 0x%08h within %0d cycles", addr, ack_limit);
    end else if (cycles != 1) begin
      errors++;
      $display("the access to 0x%08h was acknowledged after %0d cycles, not 1", addr, cycles);
    end
    if (sys_err_o !== 1'b0) begin
      errors++;
      $display("FAILED at %0t: sys_err_o expected 0, got %b", $time, sys_err_o);
    end
  endtask

  // write, then one idle cycle so the new state is readable
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, unused);
    wait_cycles(1);
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp,
                             input logic [31:0] mask, input string name);
    logic [31:0] got;
    bus_access(1'b0, addr, 32'h0, got);
    checks++;
    if ((got & mask) !== (exp & mask)) begin
      errors++;
      $display("FAILED at %0t: %s expected 0x%08h, got 0x%08h",
               $time, name, exp & mask, got & mask);
    end
  endtask

  // single output pin against the model
  task automatic expect_bit(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected %0b, got %0b", $time, name, exp, got);
    end
  endtask

  // empty bit 4, almost-full bit 5, full bit 6
  function automatic logic [31:0] sha_status_model();
    logic [31:0] w;
    w    = '0;
    w[4] = (m_fifo.size() == 0);
    w[5] = (m_fifo.size() >= fifo_words - 1);
    w[6] = (m_fifo.size() == fifo_words);
    return w;
  endfunction

  function automatic logic [31:0] unmapped_addr();
    case ($urandom % 5)
      0: return 32'h008;
      1: return 32'h108;
      2: return 32'h111;                          // hash window, not aligned
      3: return 32'h138;
      default: return 32'h200 + 4 * ($urandom % 64);
    endcase
  endfunction

  // ------------------------------
  // engine model, samples at +1 ns and drives at +2 ns
  always @(posedge bus_clk) begin
    #1;
    rd_next    = 1'b0;
    valid_next = 1'b0;
    if (bus_rstn) begin
      checks++;
      if (fifo_rd_valid_o !== rd_en_q) begin
        errors++;
        $display("FAILED at %0t: fifo_rd_valid_o expected %0b, got %0b",
                 $time, rd_en_q, fifo_rd_valid_o);
      end
      if (fifo_rd_valid_o === 1'b1) begin
        if (m_fifo.size() == 0) begin
          errors++;
          $display("the FIFO returned a word at %0t while the model holds none", $time);
        end else begin
          pop_exp = m_fifo.pop_front();
          checks++;
          if (fifo_rd_data_o !== pop_exp) begin
            errors++;
            $display("FAILED at %0t: fifo_rd_data_o expected 0x%08h, got 0x%08h",
                     $time, pop_exp, fifo_rd_data_o);
          end
        end
      end
      // ready still holds the value of the cycle before
      checks++;
      if (engine_start_o === 1'b1 && (engine_ready_i !== 1'b1 || empty_q)) begin
        errors++;
        $display("start pulse at %0t without data and ready in the cycle before", $time);
      end
      rd_next = pop_on && !fifo_empty_o && ($urandom % 4 != 0);
      if (busy) begin
        for (eng_k = 0; eng_k < 8; eng_k++) begin
          next_hash[32*eng_k +: 32] = $urandom;   // later valid cycles carry other data
        end
        if (hold > 0) hold--;
        else busy = 1'b0;                       // one low cycle between hashes
      end else if (hash_on && engine_start_o) begin
        busy = 1'b1;
        hold = 3 + $urandom % 4;
        for (eng_k = 0; eng_k < 8; eng_k++) begin
          next_hash[32*eng_k +: 32] = $urandom;
        end
        m_hash = next_hash;
        hashes_seen++;
      end
      valid_next = busy && (hold > 0);
    end
    empty_q = fifo_empty_o;
    #1;
    fifo_rd_en_i   = rd_next;
    rd_en_q        = rd_next;
    engine_ready_i = (($urandom % 2) == 1);
    hash_valid_i   = valid_next;
    hash_data_i    = next_hash;
  end

  // ------------------------------
  // main sequence
  initial begin
    seed_val       = $urandom(32'hf618);
    bus_clk        = 1'b0;
    bus_rstn       = 1'b0;
    sys_addr_i     = '0;
    sys_wdata_i    = '0;
    sys_wen_i      = 1'b0;
    sys_ren_i      = 1'b0;
    fifo_rd_en_i   = 1'b0;
    engine_ready_i = 1'b0;
    hash_valid_i   = 1'b0;
    hash_data_i    = '0;
    next_hash      = '0;
    m_ctrl         = '0;
    m_sha_ctrl     = '0;
    m_hash         = '0;
    errors         = 0;
    checks         = 0;
    timeouts       = 0;
    pop_on         = 1'b0;
    hash_on        = 1'b0;
    busy           = 1'b0;
    hold           = 0;
    hashes_seen    = 0;
    rd_en_q        = 1'b0;
    empty_q        = 1'b1;
    repeat (5) @(posedge bus_clk);
    #2;
    bus_rstn = 1'b1;
    wait_cycles(2);

    // register readback, version, unmapped
    for (i = 0; i < 60; i++) begin
      word = $urandom;
      case ($urandom % 6)
        0: begin
          bus_write(a_ctrl, word);
          m_ctrl = word;
          read_expect(a_ctrl, m_ctrl, '1, "sys_rdata_o (ctrl)");
        end
        1: begin
          bus_write(a_sha_ctrl, word);
          m_sha_ctrl = word & ~32'h2;           // reset bit clears itself
          read_expect(a_sha_ctrl, m_sha_ctrl, '1, "sys_rdata_o (sha ctrl)");
        end
        2: begin
          bus_write(a_version, word);
          read_expect(a_version, version_word, '1, "sys_rdata_o (version)");
        end
        3: begin
          s_word = unmapped_addr();
          bus_write(s_word, word);
          read_expect(s_word, 32'h0, '1, "sys_rdata_o (unmapped)");
        end
        4: begin
          k = $urandom % 8;
          read_expect(a_hash_base + 4 * k, 32'h0, '1, $sformatf("sys_rdata_o (hash %0d)", k));
        end
        default: read_expect(a_wr_count, 32'h0, '1, "sys_rdata_o (fifo count)");
      endcase
    end

    // activation follows enable and reset, one cycle late
    for (i = 0; i < 30; i++) begin
      c_word = $urandom;
      s_word = $urandom;
      bus_write(a_ctrl, c_word);
      bus_write(a_sha_ctrl, s_word);
      exp_st    = '0;
      exp_st[0] = c_word[0];
      exp_st[4] = c_word[0] & s_word[0] & !s_word[1];   // reset bit still seen
      read_expect(a_status, exp_st, '1, "sys_rdata_o (status)");
      exp_st[4] = c_word[0] & s_word[0];
      read_expect(a_status, exp_st, '1, "sys_rdata_o (status)");
      // double hash only while activated
      expect_bit("engine_dbl_hash_o", c_word[0] & s_word[0] & s_word[4], engine_dbl_hash_o);
      m_ctrl     = c_word;
      m_sha_ctrl = s_word & ~32'h2;
    end

    // fill past full with the engine idle
    bus_write(a_ctrl, 32'h1);
    bus_write(a_sha_ctrl, 32'h1);
    m_fifo.delete();
    for (i = 0; i < fifo_words + 8; i++) begin
      word = $urandom;
      bus_write(a_push, word);
      if (m_fifo.size() < fifo_words) m_fifo.push_back(word);   // full drops the push
      case ($urandom % 3)
        0: s_word = a_push;
        1: s_word = a_wr_count;
        default: s_word = a_rd_count;
      endcase
      read_expect(s_word, m_fifo.size(), '1, "sys_rdata_o (fifo count)");
      expect_bit("fifo_empty_o", m_fifo.size() == 0, fifo_empty_o);
      if (m_fifo.size() >= fifo_words - 4 || $urandom % 8 == 0) begin
        read_expect(a_sha_status, sha_status_model(), ~32'h3, "sys_rdata_o (sha status)");
      end
    end
    expect_bit("engine_dbl_hash_o", 1'b0, engine_dbl_hash_o);

    // drain through the engine port
    pop_on = 1'b1;
    n      = 0;
    while (m_fifo.size() != 0 && n < drain_limit) begin
      wait_cycles(1);
      n++;
    end
    if (m_fifo.size() != 0) begin
      timeouts++;
      $display("the FIFO did not drain, %0d words left after %0d cycles", m_fifo.size(), n);
    end
    pop_on = 1'b0;
    wait_cycles(2);
    read_expect(a_rd_count, 32'h0, '1, "sys_rdata_o (fifo count)");
    expect_bit("fifo_empty_o", 1'b1, fifo_empty_o);

    // start, hash capture, then deactivation
    for (i = 0; i < 3; i++) begin
      word = $urandom;
      bus_write(a_push, word);
      m_fifo.push_back(word);
    end
    expect_bit("fifo_empty_o", 1'b0, fifo_empty_o);
    seen0   = hashes_seen;
    hash_on = 1'b1;
    n       = 0;
    while ((hashes_seen == seen0 || busy) && n < hash_limit) begin
      wait_cycles(1);
      n++;
    end
    hash_on = 1'b0;
    if (hashes_seen == seen0 || busy) begin
      timeouts++;
      $display("no complete hash from the engine within %0d cycles", hash_limit);
    end
    wait_cycles(1);
    for (k = 0; k < 8; k++) begin
      read_expect(a_hash_base + 4 * k, m_hash[32*k +: 32], '1,
                  $sformatf("sys_rdata_o (hash %0d)", k));
    end
    bus_write(a_ctrl, 32'h0);
    m_ctrl = '0;
    m_hash = '0;
    m_fifo.delete();                            // flushed while not activated
    wait_cycles(2);
    for (k = 0; k < 8; k++) begin
      read_expect(a_hash_base + 4 * k, 32'h0, '1, $sformatf("sys_rdata_o (hash %0d)", k));
    end
    read_expect(a_push, 32'h0, '1, "sys_rdata_o (fifo count)");
    expect_bit("fifo_empty_o", 1'b1, fifo_empty_o);
    read_expect(a_status, 32'h0, '1, "sys_rdata_o (status)");
    read_expect(a_sha_status, sha_status_model(), ~32'h3, "sys_rdata_o (sha status)");

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
source/x11_pkg.sv
source/bus_regs.sv
source/sha256_fifo.sv
source/sha256_ctrl.sv
source/x11_regs_top.sv
tb/x11_regs_properties.sv
tb/tb_x11_regs.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_x11_regs
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
